// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_fphub_divider
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: files.f
rtl/fphub_div_pkg.sv
rtl/hub_special_classifier.sv
rtl/fphub_div_ctrl.sv
rtl/srt_digit_recurrence.sv
rtl/srt_quotient_convert.sv
rtl/hub_result_pack.sv
rtl/fphub_divider.sv
sim/fphub_divider_asserts.sv
sim/tb_fphub_divider.sv

// File: rtl/fphub_div_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module fphub_div_ctrl (
    input  wire  clk,
    input  wire  rst_l,
    input  wire  start,
    input  wire  is_special,
    output logic accept_normal,
    output logic load_special,
    output logic step,
    output logic pack_en,
    output logic finish,
    output logic computing
);

    fphub_div_pkg::div_state_t  state;
    fphub_div_pkg::div_state_t  state_next;
    fphub_div_pkg::iter_count_t iter_cnt;
    logic                       idle;
    logic                       last_iter;

    // ------------------------------------------------------------------------
    // Start decode and strobes
    // ------------------------------------------------------------------------
    assign idle          = (state == fphub_div_pkg::ST_IDLE);
    // Start only counts while idle
    assign accept_normal = start & idle & ~is_special;
    assign load_special  = start & idle & is_special;
    assign step          = (state == fphub_div_pkg::ST_ITERATE);
    assign pack_en       = (state == fphub_div_pkg::ST_PACK);
    assign computing     = ~idle;
    // Counter runs 0 to 25
    assign last_iter     = (iter_cnt ==
                            fphub_div_pkg::iter_count_t'(fphub_div_pkg::ITERATIONS - 1));

    always_comb begin
        state_next = state;
        case (state)
            fphub_div_pkg::ST_IDLE: begin
                if (accept_normal) begin
                    state_next = fphub_div_pkg::ST_ITERATE;
                end
            end
            fphub_div_pkg::ST_ITERATE: begin
                if (last_iter) begin
                    state_next = fphub_div_pkg::ST_PACK;
                end
            end
            fphub_div_pkg::ST_PACK: begin
                state_next = fphub_div_pkg::ST_IDLE;
            end
            default: begin
                state_next = fphub_div_pkg::ST_IDLE;
            end
        endcase
    end

    // ------------------------------------------------------------------------
    // Registers
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_l) begin
        if (!rst_l) begin
            state    <= fphub_div_pkg::ST_IDLE;
            iter_cnt <= '0;
            finish   <= 1'b0;
        end else begin
            state <= state_next;
            // Clear on accept and count each iteration
            if (accept_normal) begin
                iter_cnt <= '0;
            end else if (step) begin
                iter_cnt <= iter_cnt + 1'b1;
            end
            // One cycle pulse alongside the result load
            finish <= pack_en | load_special;
        end
    end

endmodule

`default_nettype wire

// File: rtl/fphub_div_pkg.sv
`default_nettype none

package fphub_div_pkg;

    // ------------------------------------------------------------------------
    // HUB single precision format
    // ------------------------------------------------------------------------
    localparam int EXP_W      = 8;
    localparam int MAN_W      = 23;
    localparam int EXP_BIAS   = 127;
    // All-ones exponent marks infinity
    localparam int EXP_INF    = 255;
    // One quotient digit per iteration
    localparam int ITERATIONS = 26;
    // Accept edge to finish for a normal division
    localparam int LATENCY    = ITERATIONS + 2;
    // Quiet NaN has only the top mantissa bit set
    localparam logic [MAN_W-1:0] QNAN_MANTISSA = {1'b1, {(MAN_W-1){1'b0}}};

    // ------------------------------------------------------------------------
    // Vector types
    // ------------------------------------------------------------------------
    typedef logic [EXP_W+MAN_W:0]          hub_word_t;
    typedef logic [EXP_W-1:0]              exponent_t;
    typedef logic [MAN_W-1:0]              mantissa_t;
    // Leading one, stored mantissa, implicit trailing one
    typedef logic [MAN_W+1:0]              significand_t;
    // Signed exponent before the range check
    typedef logic signed [EXP_W+1:0]       exp_wide_t;
    // Sign, two integer bits, 25 fraction bits
    typedef logic signed [MAN_W+4:0]       remainder_t;
    typedef logic [ITERATIONS-1:0]         quotient_t;
    typedef logic [$clog2(ITERATIONS)-1:0] iter_count_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ITERATE,
        ST_PACK
    } div_state_t;

    // Field view of a HUB word
    typedef struct packed {
        logic      sign;
        exponent_t exponent;
        mantissa_t mantissa;
    } hub_fields_t;

    // Signed digit, both bits low means digit 0
    typedef struct packed {
        logic pos;
        logic neg;
    } srt_digit_t;

    typedef struct packed {
        logic      is_special;
        hub_word_t result;
    } special_info_t;

endpackage

`default_nettype wire

// File: rtl/fphub_divider.sv
`timescale 1ns/1ps
`default_nettype none

module fphub_divider (
    input  wire                         clk,
    input  wire                         rst_l,
    input  wire                         start,
    input  wire fphub_div_pkg::hub_word_t x,
    input  wire fphub_div_pkg::hub_word_t d,
    output fphub_div_pkg::hub_word_t      res,
    output logic                        finish,
    output logic                        computing
);

    fphub_div_pkg::hub_fields_t    x_f;
    fphub_div_pkg::hub_fields_t    d_f;
    fphub_div_pkg::significand_t   x_sig;
    fphub_div_pkg::significand_t   d_sig;
    fphub_div_pkg::special_info_t  special;
    fphub_div_pkg::srt_digit_t     digit;
    fphub_div_pkg::quotient_t      quotient;
    logic                          accept_normal;
    logic                          load_special;
    logic                          step;
    logic                          pack_en;
    logic                          rem_negative;

    assign x_f = x;
    assign d_f = d;

    // Significand 1.m1 with the implicit HUB trailing one
    assign x_sig = {1'b1, x_f.mantissa, 1'b1};
    assign d_sig = {1'b1, d_f.mantissa, 1'b1};

    // ------------------------------------------------------------------------
    // Units
    // ------------------------------------------------------------------------
    hub_special_classifier u_classifier (
        .x       (x),
        .d       (d),
        .special (special)
    );

    fphub_div_ctrl u_ctrl (
        .clk           (clk),
        .rst_l         (rst_l),
        .start         (start),
        .is_special    (special.is_special),
        .accept_normal (accept_normal),
        .load_special  (load_special),
        .step          (step),
        .pack_en       (pack_en),
        .finish        (finish),
        .computing     (computing)
    );

    srt_digit_recurrence u_recurrence (
        .clk           (clk),
        .rst_l         (rst_l),
        .accept_normal (accept_normal),
        .step          (step),
        .x_sig         (x_sig),
        .d_sig         (d_sig),
        .digit         (digit),
        .rem_negative  (rem_negative)
    );

    srt_quotient_convert u_convert (
        .clk           (clk),
        .rst_l         (rst_l),
        .accept_normal (accept_normal),
        .step          (step),
        .digit         (digit),
        .rem_negative  (rem_negative),
        .quotient      (quotient)
    );

    hub_result_pack u_pack (
        .clk           (clk),
        .rst_l         (rst_l),
        .accept_normal (accept_normal),
        .load_special  (load_special),
        .pack_en       (pack_en),
        .x             (x),
        .d             (d),
        .special       (special),
        .quotient      (quotient),
        .res           (res)
    );

endmodule

`default_nettype wire

// File: rtl/hub_result_pack.sv
`timescale 1ns/1ps
`default_nettype none

module hub_result_pack (
    input  wire                              clk,
    input  wire                              rst_l,
    input  wire                              accept_normal,
    input  wire                              load_special,
    input  wire                              pack_en,
    input  wire fphub_div_pkg::hub_word_t      x,
    input  wire fphub_div_pkg::hub_word_t      d,
    input  wire fphub_div_pkg::special_info_t  special,
    input  wire fphub_div_pkg::quotient_t      quotient,
    output fphub_div_pkg::hub_word_t           res
);

    fphub_div_pkg::hub_fields_t x_f;
    fphub_div_pkg::hub_fields_t d_f;
    fphub_div_pkg::hub_fields_t packed_res;
    fphub_div_pkg::exp_wide_t   res_exp;
    fphub_div_pkg::exp_wide_t   norm_exp;
    fphub_div_pkg::mantissa_t   norm_man;
    logic                       res_sign;

    assign x_f = x;
    assign d_f = d;

    // Sign and biased exponent difference, held through the iterations
    always_ff @(posedge clk) begin
        if (accept_normal) begin
            res_sign <= x_f.sign ^ d_f.sign;
            res_exp  <= fphub_div_pkg::exp_wide_t'({2'b00, x_f.exponent})
                      - fphub_div_pkg::exp_wide_t'({2'b00, d_f.exponent})
                      + fphub_div_pkg::exp_wide_t'(fphub_div_pkg::EXP_BIAS);
        end
    end

    // ------------------------------------------------------------------------
    // Normalize and range check
    // ------------------------------------------------------------------------
    always_comb begin
        // Quotient lies in [2^24, 2^26), at most one position to fix
        if (quotient[fphub_div_pkg::ITERATIONS-1]) begin
            norm_man = quotient[fphub_div_pkg::MAN_W+1:2];
            norm_exp = res_exp;
        end else begin
            norm_man = quotient[fphub_div_pkg::MAN_W:1];
            norm_exp = res_exp - fphub_div_pkg::exp_wide_t'(1);
        end
        // HUB nearest rounding is plain truncation of the dropped bits
        packed_res.sign = res_sign;
        if (norm_exp < fphub_div_pkg::exp_wide_t'(1)) begin
            // Underflow to signed zero
            packed_res.exponent = '0;
            packed_res.mantissa = '0;
        end else if (norm_exp > fphub_div_pkg::exp_wide_t'(fphub_div_pkg::EXP_INF - 1)) begin
            // Overflow to signed infinity
            packed_res.exponent = fphub_div_pkg::exponent_t'(fphub_div_pkg::EXP_INF);
            packed_res.mantissa = '0;
        end else begin
            packed_res.exponent = norm_exp[fphub_div_pkg::EXP_W-1:0];
            packed_res.mantissa = norm_man;
        end
    end

    // Result held until the next load
    always_ff @(posedge clk or negedge rst_l) begin
        if (!rst_l) begin
            res <= '0;
        end else if (load_special) begin
            res <= special.result;
        end else if (pack_en) begin
            res <= packed_res;
        end
    end

endmodule

`default_nettype wire

// File: rtl/hub_special_classifier.sv
`timescale 1ns/1ps
`default_nettype none

module hub_special_classifier (
    input  wire fphub_div_pkg::hub_word_t      x,
    input  wire fphub_div_pkg::hub_word_t      d,
    output fphub_div_pkg::special_info_t       special
);

    fphub_div_pkg::hub_fields_t x_f;
    fphub_div_pkg::hub_fields_t d_f;
    fphub_div_pkg::hub_fields_t spec_f;
    logic                       x_zero;
    logic                       x_inf;
    logic                       d_zero;
    logic                       d_inf;
    logic                       res_sign;

    assign x_f = x;
    assign d_f = d;

    // Zero is exponent 0, infinity is exponent 255 with any mantissa
    assign x_zero = (x_f.exponent == '0);
    assign d_zero = (d_f.exponent == '0);
    assign x_inf  = (x_f.exponent == fphub_div_pkg::exponent_t'(fphub_div_pkg::EXP_INF));
    assign d_inf  = (d_f.exponent == fphub_div_pkg::exponent_t'(fphub_div_pkg::EXP_INF));

    // Sign follows the usual rule for every class
    assign res_sign = x_f.sign ^ d_f.sign;

    always_comb begin
        spec_f.sign     = res_sign;
        spec_f.exponent = '0;
        spec_f.mantissa = '0;
        // 0/0 and inf/inf
        if ((x_zero && d_zero) || (x_inf && d_inf)) begin
            spec_f.exponent = fphub_div_pkg::exponent_t'(fphub_div_pkg::EXP_INF);
            spec_f.mantissa = fphub_div_pkg::QNAN_MANTISSA;
        // 0/d and x/inf
        end else if (x_zero || d_inf) begin
            spec_f.exponent = '0;
        // inf/d and x/0
        end else if (x_inf || d_zero) begin
            spec_f.exponent = fphub_div_pkg::exponent_t'(fphub_div_pkg::EXP_INF);
        end
    end

    // Any zero or infinity operand skips the recurrence
    assign special.is_special = x_zero | x_inf | d_zero | d_inf;
    assign special.result     = spec_f;

endmodule

`default_nettype wire

// File: rtl/srt_digit_recurrence.sv
`timescale 1ns/1ps
`default_nettype none

module srt_digit_recurrence (
    input  wire                             clk,
    input  wire                             rst_l,
    input  wire                             accept_normal,
    input  wire                             step,
    input  wire fphub_div_pkg::significand_t x_sig,
    input  wire fphub_div_pkg::significand_t d_sig,
    output fphub_div_pkg::srt_digit_t        digit,
    output logic                            rem_negative
);

    fphub_div_pkg::remainder_t rem;
    fphub_div_pkg::remainder_t divisor;
    fphub_div_pkg::remainder_t rem_dbl;
    fphub_div_pkg::remainder_t rem_next;
    fphub_div_pkg::remainder_t half;

    // 0.5 in remainder format, 2^24 with 25 fraction bits
    assign half = fphub_div_pkg::remainder_t'(1) <<< (fphub_div_pkg::MAN_W + 1);

    // |w| < d < 2 so the doubled value still fits
    assign rem_dbl = rem <<< 1;

    // ------------------------------------------------------------------------
    // Digit selection
    // ------------------------------------------------------------------------
    always_comb begin
        digit    = '0;
        rem_next = rem_dbl;
        if (rem_dbl >= half) begin
            // Digit +1
            digit.pos = 1'b1;
            rem_next  = rem_dbl - divisor;
        end else if (rem_dbl < -half) begin
            // Digit -1
            digit.neg = 1'b1;
            rem_next  = rem_dbl + divisor;
        end
    end

    // ------------------------------------------------------------------------
    // Remainder and divisor registers
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_l) begin
        if (!rst_l) begin
            rem <= '0;
        end else if (accept_normal) begin
            // First remainder is x/2, the 25-bit significand at 2^-25 weight
            rem <= fphub_div_pkg::remainder_t'({3'b000, x_sig});
        end else if (step) begin
            rem <= rem_next;
        end
    end

    // Divisor aligned to the remainder's binary point
    always_ff @(posedge clk) begin
        if (accept_normal) begin
            divisor <= fphub_div_pkg::remainder_t'({2'b00, d_sig, 1'b0});
        end
    end

    // Sign of the held remainder, final one after the last step
    assign rem_negative = rem[$bits(fphub_div_pkg::remainder_t)-1];

endmodule

`default_nettype wire

// File: rtl/srt_quotient_convert.sv
`timescale 1ns/1ps
`default_nettype none

module srt_quotient_convert (
    input  wire                           clk,
    input  wire                           rst_l,
    input  wire                           accept_normal,
    input  wire                           step,
    input  wire fphub_div_pkg::srt_digit_t digit,
    input  wire                           rem_negative,
    output fphub_div_pkg::quotient_t       quotient
);

    // Positions of +1 and -1 digits, first digit ends up in the MSB
    fphub_div_pkg::quotient_t pos_bits;
    fphub_div_pkg::quotient_t neg_bits;

    always_ff @(posedge clk or negedge rst_l) begin
        if (!rst_l) begin
            pos_bits <= '0;
            neg_bits <= '0;
        end else if (accept_normal) begin
            pos_bits <= '0;
            neg_bits <= '0;
        end else if (step) begin
            // Shift in one digit per iteration
            pos_bits <= {pos_bits[fphub_div_pkg::ITERATIONS-2:0], digit.pos};
            neg_bits <= {neg_bits[fphub_div_pkg::ITERATIONS-2:0], digit.neg};
        end
    end

    // Redundant to binary
    // A negative final remainder means the digits overshot by one ulp
    assign quotient = pos_bits - neg_bits - fphub_div_pkg::quotient_t'(rem_negative);

endmodule

`default_nettype wire

// File: sim/fphub_divider_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module fphub_divider_asserts (
    input wire                            clk,
    input wire                            rst_l,
    input wire                            accept_normal,
    input wire                            finish,
    input wire                            computing,
    input wire fphub_div_pkg::div_state_t state
);

    // Result strobe only once the unit is idle again
    a_finish_not_computing: assert property (@(posedge clk) disable iff (!rst_l)
        !(finish && computing))
        else $error("finish high while computing");

    // One cycle pulse
    a_finish_single: assert property (@(posedge clk) disable iff (!rst_l)
        finish |=> !finish)
        else $error("finish held for two cycles");

    // Accepted normal operation starts computing on the next edge
    a_accept_computing: assert property (@(posedge clk) disable iff (!rst_l)
        accept_normal |=> computing)
        else $error("computing not raised after accept");

    a_state_legal: assert property (@(posedge clk) disable iff (!rst_l)
        state inside {fphub_div_pkg::ST_IDLE, fphub_div_pkg::ST_ITERATE,
                      fphub_div_pkg::ST_PACK})
        else $error("controller state out of range");

endmodule

bind fphub_div_ctrl fphub_divider_asserts u_asserts (
    .clk           (clk),
    .rst_l         (rst_l),
    .accept_normal (accept_normal),
    .finish        (finish),
    .computing     (computing),
    .state         (state)
);

`default_nettype wire

// File: sim/tb_fphub_divider.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fphub_divider;

    localparam int N_RANDOM    = 200;
    localparam int SPEC_ROUNDS = 4;
    localparam int N_RANGE     = 20;
    // Random, class combinations, overflow and underflow, ignored start
    localparam int NUM_OPS     = N_RANDOM + SPEC_ROUNDS * 9 + 2 * N_RANGE + 1;
    localparam int TIMEOUT     = NUM_OPS * (fphub_div_pkg::LATENCY + 4) + 100;
    // Exponent ranges for zero, infinity and moderate normal operands
    localparam int CLASS_LO [3]   = '{0, 255, 96};
    localparam int CLASS_SPAN [3] = '{1, 1, 64};

    logic                     clk;
    logic                     rst_l;
    logic                     start;
    fphub_div_pkg::hub_word_t x;
    fphub_div_pkg::hub_word_t d;
    fphub_div_pkg::hub_word_t res;
    logic                     finish;
    logic                     computing;
    logic [31:0]              rng;
    int                       cycle_count;

    fphub_divider u_dut (
        .clk       (clk),
        .rst_l     (rst_l),
        .start     (start),
        .x         (x),
        .d         (d),
        .res       (res),
        .finish    (finish),
        .computing (computing)
    );

    always #50 clk = ~clk;

    // ------------------------------------------------------------------------
    // Error reporting and compares
    // ------------------------------------------------------------------------
    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input fphub_div_pkg::hub_word_t got,
                              input fphub_div_pkg::hub_word_t expected);
        if (got !== expected)
            report_failure($sformatf("FAILED %s: got %h expected %h", name, got, expected));
    endtask

    task automatic check_bit(input string name, input logic got, input logic expected);
        if (got !== expected)
            report_failure($sformatf("FAILED %s: got %h expected %h", name, got, expected));
    endtask

    // Run limit
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT)
            report_failure("Run exceeded its cycle limit, finish never came");
    end

    // ------------------------------------------------------------------------
    // Stimulus helpers
    // ------------------------------------------------------------------------
    function automatic logic [31:0] xorshift(input logic [31:0] v);
        logic [31:0] s;
        s = v;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    task automatic draw(output logic [31:0] v);
        rng = xorshift(rng);
        v   = rng;
    endtask

    // Random sign and mantissa, exponent in [lo, lo + span)
    task automatic random_operand(input int lo, input int span,
                                  output fphub_div_pkg::hub_word_t w);
        logic [31:0] bits;
        logic [31:0] pick;
        draw(bits);
        draw(pick);
        w = {bits[31], fphub_div_pkg::exponent_t'(lo + int'(pick % 32'(span))), bits[22:0]};
    endtask

    // Reference quotient straight from the HUB division rules
    task automatic model_div(input fphub_div_pkg::hub_word_t a,
                             input fphub_div_pkg::hub_word_t b,
                             output fphub_div_pkg::hub_word_t r_word, output logic special_op);
        fphub_div_pkg::hub_fields_t fa;
        fphub_div_pkg::hub_fields_t fb;
        fphub_div_pkg::hub_fields_t r;
        logic                       a_zero;
        logic                       a_inf;
        logic                       b_zero;
        logic                       b_inf;
        logic [63:0]                sa;
        logic [63:0]                sb;
        logic [63:0]                q;
        int                         e;
        fa = a;
        fb = b;
        a_zero = (fa.exponent == '0);
        b_zero = (fb.exponent == '0);
        a_inf  = (fa.exponent == fphub_div_pkg::exponent_t'(fphub_div_pkg::EXP_INF));
        b_inf  = (fb.exponent == fphub_div_pkg::exponent_t'(fphub_div_pkg::EXP_INF));
        special_op = a_zero | a_inf | b_zero | b_inf;
        r.sign     = fa.sign ^ fb.sign;
        r.exponent = '0;
        r.mantissa = '0;
        if ((a_zero && b_zero) || (a_inf && b_inf)) begin
            r.exponent = 8'hff;
            r.mantissa = 23'h40_0000;
        end else if (a_zero || b_inf) begin
            r.exponent = '0;
        end else if (a_inf || b_zero) begin
            r.exponent = 8'hff;
        end else begin
            // Significands 1.m1, quotient floor(sx * 2^25 / sd)
            sa = {39'd0, 1'b1, fa.mantissa, 1'b1};
            sb = {39'd0, 1'b1, fb.mantissa, 1'b1};
            q  = (sa << 25) / sb;
            e  = int'(fa.exponent) - int'(fb.exponent) + fphub_div_pkg::EXP_BIAS;
            if (q[25]) begin
                r.mantissa = q[24:2];
            end else begin
                r.mantissa = q[23:1];
                e          = e - 1;
            end
            if (e < 1) begin
                r.mantissa = '0;
            end else if (e > 254) begin
                r.exponent = 8'hff;
                r.mantissa = '0;
            end else begin
                r.exponent = e[7:0];
            end
        end
        r_word = r;
    endtask

    // ------------------------------------------------------------------------
    // One division, with latency and level checks
    // ------------------------------------------------------------------------
    task automatic run_op(input fphub_div_pkg::hub_word_t a,
                          input fphub_div_pkg::hub_word_t b, input logic interfere);
        fphub_div_pkg::hub_word_t expect_res;
        logic                     special_op;
        int                       edges;
        int                       want;
        model_div(a, b, expect_res, special_op);
        want = special_op ? 1 : fphub_div_pkg::LATENCY;
        @(posedge clk);
        x     <= a;
        d     <= b;
        start <= 1'b1;
        // Sampling edge counts as the first
        @(posedge clk);
        edges = 1;
        if (interfere) begin
            // Swapped operands with start still high, must be ignored
            x <= b;
            d <= a;
        end else begin
            start <= 1'b0;
        end
        @(negedge clk);
        while (!finish) begin
            check_bit("computing", computing, 1'b1);
            @(posedge clk);
            edges = edges + 1;
            if (edges == 3)
                start <= 1'b0;
            @(negedge clk);
        end
        if (edges != want)
            report_failure($sformatf("finish came %0d edges after start instead of %0d",
                                     edges, want));
        check_bit("computing", computing, 1'b0);
        check_word("res", res, expect_res);
        // Single pulse, result held
        @(posedge clk);
        @(negedge clk);
        check_bit("finish", finish, 1'b0);
        check_word("res", res, expect_res);
    endtask

    // ------------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------------
    initial begin
        fphub_div_pkg::hub_word_t a;
        fphub_div_pkg::hub_word_t b;
        clk         = 1'b0;
        rst_l       = 1'b0;
        start       = 1'b0;
        x           = '0;
        d           = '0;
        cycle_count = 0;
        rng         = 32'hf186_819e;
        repeat (3) @(posedge clk);
        rst_l <= 1'b1;
        @(negedge clk);
        check_word("res", res, '0);
        check_bit("finish", finish, 1'b0);
        check_bit("computing", computing, 1'b0);

        // Normal operands, moderate exponents
        for (int i = 0; i < N_RANDOM; i++) begin
            random_operand(96, 64, a);
            random_operand(96, 64, b);
            run_op(a, b, 1'b0);
        end

        // Every pairing of zero, infinity and normal
        for (int round = 0; round < SPEC_ROUNDS; round++) begin
            for (int cx = 0; cx < 3; cx++) begin
                for (int cd = 0; cd < 3; cd++) begin
                    random_operand(CLASS_LO[cx], CLASS_SPAN[cx], a);
                    random_operand(CLASS_LO[cd], CLASS_SPAN[cd], b);
                    run_op(a, b, 1'b0);
                end
            end
        end

        // Exponent range forced out at both ends
        for (int i = 0; i < N_RANGE; i++) begin
            random_operand(200, 55, a);
            random_operand(1, 40, b);
            run_op(a, b, 1'b0);
            random_operand(1, 40, a);
            random_operand(180, 75, b);
            run_op(a, b, 1'b0);
        end

        // Start while busy
        random_operand(96, 64, a);
        random_operand(96, 64, b);
        run_op(a, b, 1'b1);

        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire
